/* Makefile */
TOP = board_eval_tb

.PHONY: build run clean

build:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps -f vlog.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Test FAILED" sim.log; then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "Test OK" sim.log; then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

/* board_eval.sv */
module board_eval
   import chess_pkg::*, eval_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  logic        board_valid,
   input  board_t      board_in,
   input  logic        is_attacking_done,
   input  logic        clear_eval,
   input  eval_terms_t terms,
   output eval_t       eval,
   output logic        eval_valid
);

   board_t      board;
   rank_score_t rank_scores [num_ranks];

   position_capture u_capture
   (
      .clk               (clk),
      .reset             (reset),
      .board_valid       (board_valid),
      .is_attacking_done (is_attacking_done),
      .clear_eval        (clear_eval),
      .board_in          (board_in),
      .board             (board),
      .eval_valid        (eval_valid)
   );

   // One scorer per rank.
   for (genvar r = 0; r < num_ranks; r++)
   begin : g_rank
      rank_scorer u_rank
      (
         .clk        (clk),
         .rank       (board[r]),
         .rank_score (rank_scores[r])
      );
   end

   eval_sum u_sum
   (
      .clk         (clk),
      .rank_scores (rank_scores),
      .terms       (terms),
      .eval        (eval)
   );

endmodule

/* board_eval_assert.sv */
module board_eval_assert
   import eval_pkg::*;
(
   input logic        clk,
   input logic        reset,
   input logic        is_attacking_done,
   input logic        clear_eval,
   input eval_state_t state,
   input eval_t       eval,
   input logic        eval_valid
);

   timeunit 1ns;
   timeprecision 100ps;

   int error_count = 0;

   a_reset_valid_low: assert property (@(posedge clk) reset |=> !eval_valid)
      else
      begin
         $error("eval_valid high in the cycle after reset");
         error_count++;
      end

   // Strobe sampled in the wait state sets the flag four edges later.
   a_fixed_latency: assert property (@(posedge clk) disable iff (reset)
      (state == st_wait_attack && is_attacking_done) |-> ##5 $rose(eval_valid))
      else
      begin
         $error("eval_valid did not rise four cycles after is_attacking_done");
         error_count++;
      end

   a_result_held: assert property (@(posedge clk) disable iff (reset)
      (eval_valid && state == st_done && !clear_eval) |=> (eval_valid && $stable(eval)))
      else
      begin
         $error("eval or eval_valid changed while the result was held");
         error_count++;
      end

endmodule

bind board_eval board_eval_assert u_assert
(
   .clk               (clk),
   .reset             (reset),
   .is_attacking_done (is_attacking_done),
   .clear_eval        (clear_eval),
   .state             (u_capture.state),
   .eval              (eval),
   .eval_valid        (eval_valid)
);

/* board_eval_tb.sv */
module board_eval_tb
   import chess_pkg::*, eval_pkg::*;
;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int wait_limit = 100;

   logic        clk = 1'b0;
   logic        reset;
   logic        board_valid;
   board_t      board_in;
   logic        is_attacking_done;
   logic        clear_eval;
   eval_terms_t terms;
   eval_t       eval;
   logic        eval_valid;

   int           seed = 32'h2501d022;
   eval_t        expected_q [$];
   int           checks_done = 0;
   int           err_count = 0;
   int           err_mark = 0;
   int           tests_passed = 0;
   int           tests_failed = 0;
   bit           stim_done = 1'b0;
   logic [255:0] opening;
   logic [255:0] bits;
   logic [14:0]  raw_terms;
   eval_terms_t  side;

   board_eval uut (.*);

   always #5 clk = ~clk;

   // Material of each code, then mobility and the signed tie-break.
   function automatic eval_t reference_eval(input logic [255:0] b, input eval_terms_t t);
      int         total;
      logic [3:0] code;
      total = 0;
      for (int sq = 0; sq < 64; sq++)
      begin
         code = b[sq*4 +: 4];
         case (code)
            4'd1:    total += value_pawn;
            4'd2:    total += value_knight;
            4'd3:    total += value_bishop;
            4'd4:    total += value_rook;
            4'd5:    total += value_queen;
            4'd6:    total += value_king;
            4'd9:    total -= value_pawn;
            4'd10:   total -= value_knight;
            4'd11:   total -= value_bishop;
            4'd12:   total -= value_rook;
            4'd13:   total -= value_queen;
            4'd14:   total -= value_king;
            default: total += 0; // Empty and unused codes.
         endcase
      end
      total += 2 * int'(t.white_pop) - 2 * int'(t.black_pop);
      if (t.use_random_bit && t.random_bit)
      begin
         total += t.white_to_move ? 1 : -1;
      end
      return eval_t'(total);
   endfunction

   function automatic logic [255:0] random_bits();
      logic [255:0] value;
      for (int w = 0; w < 8; w++)
      begin
         value[w*32 +: 32] = $random(seed);
      end
      return value;
   endfunction

   task automatic report_mismatch(input string msg);
      $display("[FAIL] %0.1f ns: %s", $realtime, msg);
      err_count++;
   endtask

   task automatic abort_run(input string why);
      $display("Timeout: %s", why);
      $display("Test FAILED");
      $finish;
   endtask

   task automatic end_test(input string name);
      if (err_count == err_mark)
      begin
         $display("%s: pass", name);
         tests_passed++;
      end
      else
      begin
         $display("%s: fail, %0d errors", name, err_count - err_mark);
         tests_failed++;
      end
      err_mark = err_count;
   endtask

   // Capture, optional wait, attack strobe, latency, hold and clear.
   task automatic evaluate(input logic [255:0] b, input eval_terms_t t, input int hold,
                           input bit scramble);
      int n;
      int seen;
      seen = checks_done;
      expected_q.push_back(reference_eval(b, t));
      board_in = board_t'(b);
      board_valid = 1'b1;
      @(posedge clk);
      #1;
      board_valid = 1'b0;
      for (n = 0; n < hold; n++)
      begin
         if (scramble)
         begin
            board_in = board_t'(random_bits());
         end
         @(posedge clk);
         #1;
         assert (!eval_valid) else report_mismatch("eval_valid high before attack counts");
      end
      terms = t;
      is_attacking_done = 1'b1;
      @(posedge clk);
      #1;
      is_attacking_done = 1'b0;
      n = 0;
      while (!eval_valid)
      begin
         if (scramble)
         begin
            board_in = board_t'(random_bits());
         end
         @(posedge clk);
         #1;
         n++;
         if (n > wait_limit)
         begin
            abort_run("eval_valid never rose after is_attacking_done.");
         end
      end
      assert (n == 4) else report_mismatch($sformatf("eval_valid rose after %0d cycles", n));
      repeat (3)
      begin
         if (scramble)
         begin
            board_in = board_t'(random_bits());
         end
         @(posedge clk);
         #1;
         assert (eval_valid) else report_mismatch("eval_valid fell without clear_eval");
      end
      clear_eval = 1'b1;
      @(posedge clk);
      #1;
      clear_eval = 1'b0;
      assert (eval_valid) else report_mismatch("eval_valid fell on the clear_eval edge");
      @(posedge clk);
      #1;
      assert (!eval_valid) else report_mismatch("eval_valid still high after clear_eval");
      n = 0;
      while (checks_done == seen)
      begin
         @(posedge clk);
         #1;
         n++;
         if (n > wait_limit)
         begin
            abort_run("the result was never compared.");
         end
      end
   endtask

   // Compares each result at the falling edge, where eval is settled.
   initial
   begin : compare_results
      eval_t expected;
      int    waited;
      forever
      begin
         waited = 0;
         while (expected_q.size() == 0 && !stim_done)
         begin
            @(negedge clk);
            waited++;
            if (waited > wait_limit)
            begin
               abort_run("no new evaluation was started.");
            end
         end
         if (stim_done)
         begin
            break;
         end
         waited = 0;
         while (!eval_valid)
         begin
            @(negedge clk);
            waited++;
            if (waited > wait_limit)
            begin
               abort_run("eval_valid did not rise for the compare.");
            end
         end
         expected = expected_q.pop_front();
         assert (eval == expected) else
            report_mismatch($sformatf("eval expected %0d, got %0d", expected, eval));
         checks_done++;
      end
   end

   initial
   begin
      reset = 1'b1;
      board_valid = 1'b0;
      board_in = board_t'(256'h0);
      is_attacking_done = 1'b0;
      clear_eval = 1'b0;
      terms = '0;
      opening = {32'hcabedbac, 32'h99999999, 128'h0, 32'h11111111, 32'h42365324};
      repeat (10) @(posedge clk);
      #1;
      reset = 1'b0;
      @(posedge clk);
      #1;
      assert (!eval_valid) else report_mismatch("eval_valid high after reset");
      evaluate(256'h0, '0, 0, 1'b0);
      end_test("empty board");
      side = '{white_pop: 6'd20, black_pop: 6'd13, default: '0};
      evaluate(opening, side, 0, 1'b0);
      end_test("opening position");
      evaluate(opening, side, 20, 1'b0);
      end_test("strobe timing");
      side = '{use_random_bit: 1'b1, random_bit: 1'b1, white_to_move: 1'b1, default: '0};
      evaluate(opening, side, 0, 1'b0);
      side.white_to_move = 1'b0;
      evaluate(opening, side, 0, 1'b0);
      side.use_random_bit = 1'b0;
      evaluate(opening, side, 0, 1'b0);
      end_test("tie-break");
      repeat (50)
      begin
         bits = random_bits();
         raw_terms = $random(seed);
         side = raw_terms;
         evaluate(bits, side, 0, 1'b0);
      end
      end_test("random boards");
      bits = random_bits();
      raw_terms = $random(seed);
      side = raw_terms;
      evaluate(bits, side, 5, 1'b1); // Board input churns after capture.
      end_test("board hold");
      stim_done = 1'b1;
      repeat (2) @(posedge clk);
      $display("Summary: %0d tests passed, %0d failed, %0d assertion failures",
               tests_passed, tests_failed, uut.u_assert.error_count);
      if (err_count == 0 && tests_failed == 0 && uut.u_assert.error_count == 0)
      begin
         $display("Test OK");
      end
      else
      begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

/* chess_pkg.sv */
package chess_pkg;

   localparam int num_files = 8;
   localparam int num_ranks = 8;

   // Square codes as delivered by the move generator.
   typedef enum logic [3:0]
   {
      empty        = 4'd0,
      white_pawn   = 4'd1,
      white_knight = 4'd2,
      white_bishop = 4'd3,
      white_rook   = 4'd4,
      white_queen  = 4'd5,
      white_king   = 4'd6,
      black_pawn   = 4'd9,
      black_knight = 4'd10,
      black_bishop = 4'd11,
      black_rook   = 4'd12,
      black_queen  = 4'd13,
      black_king   = 4'd14
   } piece_t; // Codes 7, 8 and 15 are never placed.

   // File 0 sits in the lowest nibble.
   typedef piece_t [num_files-1:0] rank_t;

   // Square rank * 8 + file starts at bit 4 * index.
   typedef rank_t [num_ranks-1:0] board_t;

endpackage

/* eval_pkg.sv */
package eval_pkg;

   // Material in centipawns.
   localparam int value_pawn   = 100;
   localparam int value_knight = 310;
   localparam int value_bishop = 320;
   localparam int value_rook   = 500;
   localparam int value_queen  = 900;
   localparam int value_king   = 5000;

   localparam int pop_shift  = 1; // Two points per attacked square.
   localparam int pop_width  = 6;

   localparam int square_width = 14;
   localparam int rank_width   = 17; // Eight kings fit with sign.
   localparam int eval_width   = 22;

   typedef logic signed [square_width-1:0] square_score_t;
   typedef logic signed [rank_width-1:0]   rank_score_t;
   typedef logic signed [eval_width-1:0]   eval_t;
   typedef logic [pop_width-1:0]           pop_t;

   // Side terms supplied with is_attacking_done.
   typedef struct packed
   {
      pop_t white_pop;
      pop_t black_pop;
      logic use_random_bit;
      logic random_bit;
      logic white_to_move;
   } eval_terms_t;

   typedef enum logic [2:0]
   {
      st_idle,
      st_wait_attack,
      st_score,
      st_sum,
      st_total,
      st_done
   } eval_state_t;

endpackage

/* eval_sum.sv */
module eval_sum
   import chess_pkg::*, eval_pkg::*;
(
   input  logic        clk,
   input  rank_score_t rank_scores [num_ranks],
   input  eval_terms_t terms,
   output eval_t       eval
);

   eval_t tie_break;
   eval_t white_mob;
   eval_t black_mob;
   eval_t mobility;
   eval_t total;

   // Side to move decides the sign of the random bit.
   always_comb
   begin
      if (!terms.use_random_bit)
      begin
         tie_break = '0;
      end
      else if (terms.white_to_move)
      begin
         tie_break = eval_t'(terms.random_bit);
      end
      else
      begin
         tie_break = -eval_t'(terms.random_bit);
      end
   end

   assign white_mob = eval_t'(terms.white_pop) <<< pop_shift;
   assign black_mob = eval_t'(terms.black_pop) <<< pop_shift;

   always_ff @(posedge clk)
   begin
      mobility <= white_mob - black_mob + tie_break;
   end

   always_comb
   begin
      total = mobility;
      for (int r = 0; r < num_ranks; r++)
      begin
         total = total + eval_t'(rank_scores[r]); // Sign extended.
      end
   end

   // One cycle after the rank sums.
   always_ff @(posedge clk)
   begin
      eval <= total;
   end

endmodule

/* position_capture.sv */
module position_capture
   import chess_pkg::*, eval_pkg::*;
(
   input  logic   clk,
   input  logic   reset,
   input  logic   board_valid,
   input  logic   is_attacking_done,
   input  logic   clear_eval,
   input  board_t board_in,
   output board_t board,
   output logic   eval_valid
);

   eval_state_t state;

   // Board follows the input while idle and freezes once a strobe is seen.
   always_ff @(posedge clk)
   begin
      if (state == st_idle)
      begin
         board <= board_in;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state <= st_idle;
      end
      else
      begin
         case (state)
            st_idle:
            begin
               if (board_valid)
               begin
                  state <= st_wait_attack;
               end
            end
            st_wait_attack:
            begin
               if (is_attacking_done)
               begin
                  state <= st_score; // Attack counts and terms now stable.
               end
            end
            st_score:
            begin
               state <= st_sum;
            end
            st_sum:
            begin
               state <= st_total;
            end
            st_total:
            begin
               state <= st_done;
            end
            st_done:
            begin
               if (clear_eval)
               begin
                  state <= st_idle;
               end
            end
            default:
            begin
               state <= st_idle;
            end
         endcase
      end
   end

   // One cycle behind st_done, so the flag trails the state by an edge.
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         eval_valid <= 1'b0;
      end
      else
      begin
         eval_valid <= (state == st_done);
      end
   end

endmodule

/* rank_scorer.sv */
module rank_scorer
   import chess_pkg::*, eval_pkg::*;
(
   input  logic        clk,
   input  rank_t       rank,
   output rank_score_t rank_score
);

   square_score_t square_scores [num_files];
   rank_score_t   rank_sum;

   function automatic square_score_t piece_value(input piece_t piece);
      case (piece)
         white_pawn:   return square_score_t'(value_pawn);
         white_knight: return square_score_t'(value_knight);
         white_bishop: return square_score_t'(value_bishop);
         white_rook:   return square_score_t'(value_rook);
         white_queen:  return square_score_t'(value_queen);
         white_king:   return square_score_t'(value_king);
         black_pawn:   return -square_score_t'(value_pawn);
         black_knight: return -square_score_t'(value_knight);
         black_bishop: return -square_score_t'(value_bishop);
         black_rook:   return -square_score_t'(value_rook);
         black_queen:  return -square_score_t'(value_queen);
         black_king:   return -square_score_t'(value_king);
         default:      return '0; // Empty and unused codes.
      endcase
   endfunction

   // First stage registers the material of each square.
   always_ff @(posedge clk)
   begin
      for (int f = 0; f < num_files; f++)
      begin
         square_scores[f] <= piece_value(rank[f]);
      end
   end

   always_comb
   begin
      rank_sum = '0;
      for (int f = 0; f < num_files; f++)
      begin
         rank_sum = rank_sum + rank_score_t'(square_scores[f]);
      end
   end

   // Stage two.
   always_ff @(posedge clk)
   begin
      rank_score <= rank_sum;
   end

endmodule

/* vlog.f */
chess_pkg.sv
eval_pkg.sv
position_capture.sv
rank_scorer.sv
eval_sum.sv
board_eval.sv
board_eval_assert.sv
board_eval_tb.sv
